//--- design/cache_ctrl.sv
// cache FSM: hits, pass-through, write-back, fetch and flush sequencing
// the processor holds its request stable until busy drops; one access at a time
// flush is taken only in IDLE with no request pending
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; #(
    parameter int    CACHE_SIZE          = 1024,
    parameter int    BLOCK_SIZE          = 2,
    parameter word_t NONCACHE_START_ADDR = 32'h8000_0000
) (
    input  logic      CLK,
    input  logic      nRST,
    input  bus_req_t  proc_req,
    output bus_rsp_t  proc_rsp,
    output bus_req_t  mem_req,
    input  bus_rsp_t  mem_rsp,
    input  logic      flush,
    output logic      flush_done,
    output logic      hit,
    output set_idx_t  lookup_set,
    output tag_t      lookup_tag,
    output logic      rd_way,
    output word_idx_t rd_word,
    output frame_wr_t frame_wr,
    input  logic      way_hit,
    input  logic      hit_way,
    input  logic      victim_way,
    input  logic      victim_dirty,
    input  tag_t      victim_tag,
    input  word_t     rd_data
);

    localparam int N_SETS    = CACHE_SIZE / (BLOCK_SIZE * 4 * 2);
    localparam int WORD_BITS = $clog2(BLOCK_SIZE);
    localparam int SET_LSB   = 2 + WORD_BITS;               // byte offset plus word index
    localparam int TAG_LSB   = SET_LSB + $clog2(N_SETS);

    ctrl_state_t state_q, state_d;
    logic [3:0]  word_cnt_q, word_cnt_d;    // counts up to BLOCK_SIZE inclusive
    set_idx_t    set_cnt_q, set_cnt_d;      // flush walk
    logic        way_cnt_q, way_cnt_d;      // ways examined in the current set
    word_t       blk_addr_q, blk_addr_d;    // base address of the block in transfer

    logic      req_any;
    logic      pass_through;
    logic      req_hit;
    logic      finish_word;
    logic      last_frame;
    word_idx_t req_word;
    set_idx_t  req_set;
    tag_t      req_tag;

    // block base address from tag and set
    function automatic word_t block_base(tag_t t, set_idx_t s);
        return (word_t'(t) << TAG_LSB) | (word_t'(s) << SET_LSB);
    endfunction

    // address decode, shifts keep zero-width fields harmless
    assign req_any      = proc_req.ren | proc_req.wen;
    assign pass_through = proc_req.addr >= NONCACHE_START_ADDR;
    assign req_word     = word_idx_t'((proc_req.addr >> 2) & word_t'(BLOCK_SIZE - 1));
    assign req_set      = set_idx_t'((proc_req.addr >> SET_LSB) & word_t'(N_SETS - 1));
    assign req_tag      = tag_t'(proc_req.addr >> TAG_LSB);

    assign req_hit     = req_any & ~pass_through & way_hit;
    assign hit         = (state_q == IDLE) & req_hit;   // never high on pass-through
    assign finish_word = word_cnt_q == 4'(BLOCK_SIZE);
    assign last_frame  = way_cnt_q & (set_cnt_q == set_idx_t'(N_SETS - 1));

    // store lookup and read selection
    always_comb begin
        lookup_tag = req_tag;
        if (state_q == FLUSH_SCAN || state_q == FLUSH_FRAME) begin
            lookup_set = set_cnt_q;     // flush walks the sets
        end else begin
            lookup_set = req_set;       // held request during a miss
        end
        if (state_q == IDLE) begin
            rd_way  = hit_way;
            rd_word = req_word;
        end else begin
            rd_way  = victim_way;       // victim stays put, LRU untouched mid-transfer
            rd_word = word_idx_t'(word_cnt_q);
        end
    end

    // next state, bus driving and store commands
    always_comb begin
        state_d    = state_q;
        word_cnt_d = word_cnt_q;
        set_cnt_d  = set_cnt_q;
        way_cnt_d  = way_cnt_q;
        blk_addr_d = blk_addr_q;
        flush_done = 1'b0;

        proc_rsp.busy  = 1'b1;          // high unless an access completes
        proc_rsp.rdata = rd_data;

        mem_req.ren     = 1'b0;
        mem_req.wen     = 1'b0;
        mem_req.addr    = blk_addr_q | (word_t'(word_cnt_q) << 2);
        mem_req.wdata   = rd_data;
        mem_req.byte_en = '1;           // block beats move whole words

        frame_wr         = '0;
        frame_wr.set     = lookup_set;
        frame_wr.way     = rd_way;
        frame_wr.word    = rd_word;
        frame_wr.tag     = req_tag;
        frame_wr.data    = mem_rsp.rdata;
        frame_wr.byte_en = '1;

        case (state_q)
            IDLE: begin
                if (req_any && pass_through) begin
                    // straight to memory, no allocation
                    mem_req.ren     = proc_req.ren;
                    mem_req.wen     = proc_req.wen;
                    mem_req.addr    = proc_req.addr;
                    mem_req.wdata   = proc_req.wdata;
                    mem_req.byte_en = proc_req.byte_en;
                    proc_rsp.busy   = mem_rsp.busy;
                    proc_rsp.rdata  = mem_rsp.rdata;
                end else if (req_hit) begin
                    proc_rsp.busy  = 1'b0;      // same-cycle answer
                    frame_wr.touch = 1'b1;
                    if (proc_req.wen) begin
                        frame_wr.data_we    = 1'b1;
                        frame_wr.mark_dirty = 1'b1;
                        frame_wr.data       = proc_req.wdata;
                        frame_wr.byte_en    = proc_req.byte_en;
                    end
                end else if (req_any) begin
                    if (victim_dirty) begin
                        blk_addr_d = block_base(victim_tag, req_set);   // old block first
                        state_d    = WB;
                    end else begin
                        blk_addr_d = block_base(req_tag, req_set);
                        state_d    = FETCH;
                    end
                end else if (flush) begin
                    set_cnt_d = '0;
                    way_cnt_d = 1'b0;
                    state_d   = FLUSH_SCAN;
                end
            end

            WB, FLUSH_FRAME: begin
                if (finish_word) begin
                    // finishing cycle, victim now matches memory
                    word_cnt_d     = '0;
                    frame_wr.clean = 1'b1;
                    if (state_q == WB) begin
                        blk_addr_d = block_base(req_tag, req_set);
                        state_d    = FETCH;
                    end else begin
                        state_d = FLUSH_SCAN;   // rescan sees it clean
                    end
                end else begin
                    mem_req.wen = 1'b1;
                    if (!mem_rsp.busy) begin
                        word_cnt_d = word_cnt_q + 4'd1;
                    end
                end
            end

            FETCH: begin
                if (finish_word) begin
                    word_cnt_d    = '0;
                    frame_wr.fill = 1'b1;   // valid plus new tag, retried request hits
                    state_d       = IDLE;
                end else begin
                    mem_req.ren = 1'b1;
                    if (!mem_rsp.busy) begin
                        frame_wr.data_we = 1'b1;    // full word from memory
                        word_cnt_d       = word_cnt_q + 4'd1;
                    end
                end
            end

            FLUSH_SCAN: begin
                // ways are visited in victim order; touching each examined way
                // flips the victim, and two touches leave the LRU bit as it was
                if (victim_dirty) begin
                    blk_addr_d = block_base(victim_tag, set_cnt_q);
                    state_d    = FLUSH_FRAME;
                end else begin
                    frame_wr.touch = 1'b1;
                    way_cnt_d      = ~way_cnt_q;
                    if (way_cnt_q) begin
                        set_cnt_d = set_cnt_q + 1'b1;
                    end
                    if (last_frame) begin
                        flush_done = 1'b1;      // one-cycle pulse
                        set_cnt_d  = '0;
                        state_d    = IDLE;
                    end
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state_q    <= IDLE;
            word_cnt_q <= '0;
            set_cnt_q  <= '0;
            way_cnt_q  <= 1'b0;
        end else begin
            state_q    <= state_d;
            word_cnt_q <= word_cnt_d;
            set_cnt_q  <= set_cnt_d;
            way_cnt_q  <= way_cnt_d;
        end
    end

    // block address only loads on a miss or a dirty frame found in flush
    always_ff @(posedge CLK) begin
        blk_addr_q <= blk_addr_d;
    end

endmodule

//--- design/cache_pkg.sv
// shared types for the two-way write-back L1 data cache
// tag and set index are sized for the extreme configurations, unused upper bits stay zero
package cache_pkg;

    localparam int TAG_BITS_MAX  = 30;  // 8-byte cache, one set, one-word blocks
    localparam int SET_BITS_MAX  = 10;  // covers the largest set count
    localparam int WORD_IDX_BITS = 3;   // up to 8 words per block

    typedef logic [31:0]                word_t;
    typedef logic [3:0]                 byte_en_t;
    typedef logic [TAG_BITS_MAX-1:0]    tag_t;
    typedef logic [SET_BITS_MAX-1:0]    set_idx_t;
    typedef logic [WORD_IDX_BITS-1:0]   word_idx_t;

    // request side of the processor and memory bus
    typedef struct packed {
        logic     ren;
        logic     wen;
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } bus_req_t;

    // response side, busy low completes a beat
    typedef struct packed {
        logic  busy;
        word_t rdata;
    } bus_rsp_t;

    // one store update, applied at the next clock edge
    typedef struct packed {
        logic      data_we;     // write one word, lanes merged
        logic      fill;        // set valid, load new tag
        logic      mark_dirty;
        logic      clean;
        logic      touch;       // record way as most recently used
        set_idx_t  set;
        logic      way;
        word_idx_t word;
        tag_t      tag;
        word_t     data;
        byte_en_t  byte_en;
    } frame_wr_t;

    typedef enum logic [2:0] {
        IDLE,
        WB,           // victim write-back before a fetch
        FETCH,
        FLUSH_SCAN,
        FLUSH_FRAME
    } ctrl_state_t;

    // byte-lane merge, each set enable takes the new lane
    function automatic word_t merge_bytes(word_t old_w, word_t new_w, byte_en_t be);
        word_t merged;
        merged = old_w;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                merged[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

//--- design/cache_store.sv
// frame storage for two ways per set plus one LRU bit per set
// reads are combinational, all updates land on the next rising edge
`timescale 1ns/1ps

module cache_store import cache_pkg::*; #(
    parameter int CACHE_SIZE = 1024,  // bytes, power of two
    parameter int BLOCK_SIZE = 2      // words per block, power of two
) (
    input  logic      CLK,
    input  logic      nRST,
    input  set_idx_t  lookup_set,
    input  tag_t      lookup_tag,
    input  logic      rd_way,
    input  word_idx_t rd_word,
    input  frame_wr_t frame_wr,
    output logic      way_hit,
    output logic      hit_way,
    output logic      victim_way,
    output logic      victim_dirty,
    output tag_t      victim_tag,
    output word_t     rd_data
);

    localparam int N_SETS = CACHE_SIZE / (BLOCK_SIZE * 4 * 2);
    // index widths kept at one bit minimum so arrays stay addressable
    localparam int SET_W  = (N_SETS > 1) ? $clog2(N_SETS) : 1;
    localparam int WORD_W = (BLOCK_SIZE > 1) ? $clog2(BLOCK_SIZE) : 1;
    localparam int TAG_W  = 30 - $clog2(N_SETS) - $clog2(BLOCK_SIZE);

    // per-frame state
    logic [N_SETS-1:0][1:0] valid_q;
    logic [N_SETS-1:0][1:0] dirty_q;
    logic [N_SETS-1:0]      lru_q;      // way used last in each set
    logic [TAG_W-1:0]       tag_q  [N_SETS][2];
    word_t                  data_q [N_SETS][2][BLOCK_SIZE];

    logic [SET_W-1:0]  rs;      // lookup set
    logic [SET_W-1:0]  ws;      // update set
    logic [WORD_W-1:0] rw;
    logic [WORD_W-1:0] ww;
    logic [1:0]        match;

    assign rs = lookup_set[SET_W-1:0];      // upper bits are zero
    assign ws = frame_wr.set[SET_W-1:0];
    assign rw = rd_word[WORD_W-1:0];
    assign ww = frame_wr.word[WORD_W-1:0];

    // tag compare on both ways at once
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            match[i] = valid_q[rs][i] && (tag_q[rs][i] == lookup_tag[TAG_W-1:0]);
        end
    end

    assign way_hit = |match;
    assign hit_way = match[1];  // a tag lives in one way only

    // replacement takes the way not used last
    assign victim_way   = ~lru_q[rs];
    assign victim_dirty = dirty_q[rs][victim_way];
    assign victim_tag   = tag_t'(tag_q[rs][victim_way]);   // zero-extend to full tag_t

    assign rd_data = data_q[rs][rd_way][rw];

    // data and tag arrays
    always_ff @(posedge CLK) begin
        if (frame_wr.data_we) begin
            data_q[ws][frame_wr.way][ww] <= merge_bytes(data_q[ws][frame_wr.way][ww],
                                                        frame_wr.data, frame_wr.byte_en);
        end
        if (frame_wr.fill) begin
            tag_q[ws][frame_wr.way] <= frame_wr.tag[TAG_W-1:0];
        end
    end

    // valid, dirty and LRU bits
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;  // every frame invalid and clean
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (frame_wr.fill) begin
                valid_q[ws][frame_wr.way] <= 1'b1;
            end
            if (frame_wr.mark_dirty) begin
                dirty_q[ws][frame_wr.way] <= 1'b1;
            end else if (frame_wr.clean) begin
                dirty_q[ws][frame_wr.way] <= 1'b0;
            end
            if (frame_wr.touch) begin
                lru_q[ws] <= frame_wr.way;
            end
        end
    end

endmodule

//--- design/l1_cache.sv
// two-way write-back L1 data cache, top level
// CACHE_SIZE up to 4096 bytes, BLOCK_SIZE 1 to 8 words, both powers of two
// accesses at or above NONCACHE_START_ADDR bypass the cache
`timescale 1ns/1ps

module l1_cache import cache_pkg::*; #(
    parameter int    CACHE_SIZE          = 1024,
    parameter int    BLOCK_SIZE          = 2,
    parameter word_t NONCACHE_START_ADDR = 32'h8000_0000
) (
    input  logic     CLK,
    input  logic     nRST,
    input  bus_req_t proc_req,
    output bus_rsp_t proc_rsp,
    output bus_req_t mem_req,
    input  bus_rsp_t mem_rsp,
    input  logic     flush,
    output logic     flush_done,
    output logic     hit
);

    // controller to store
    set_idx_t  lookup_set;
    tag_t      lookup_tag;
    logic      rd_way;
    word_idx_t rd_word;
    frame_wr_t frame_wr;

    // store to controller
    logic      way_hit;
    logic      hit_way;
    logic      victim_way;
    logic      victim_dirty;
    tag_t      victim_tag;
    word_t     rd_data;

    cache_ctrl #(
        .CACHE_SIZE          (CACHE_SIZE),
        .BLOCK_SIZE          (BLOCK_SIZE),
        .NONCACHE_START_ADDR (NONCACHE_START_ADDR)
    ) u_ctrl (
        .CLK          (CLK),
        .nRST         (nRST),
        .proc_req     (proc_req),
        .proc_rsp     (proc_rsp),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .flush        (flush),
        .flush_done   (flush_done),
        .hit          (hit),
        .lookup_set   (lookup_set),
        .lookup_tag   (lookup_tag),
        .rd_way       (rd_way),
        .rd_word      (rd_word),
        .frame_wr     (frame_wr),
        .way_hit      (way_hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .rd_data      (rd_data)
    );

    cache_store #(
        .CACHE_SIZE (CACHE_SIZE),
        .BLOCK_SIZE (BLOCK_SIZE)
    ) u_store (
        .CLK          (CLK),
        .nRST         (nRST),
        .lookup_set   (lookup_set),
        .lookup_tag   (lookup_tag),
        .rd_way       (rd_way),
        .rd_word      (rd_word),
        .frame_wr     (frame_wr),
        .way_hit      (way_hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .rd_data      (rd_data)
    );

endmodule

//--- list.f
design/cache_pkg.sv
design/cache_store.sv
design/cache_ctrl.sv
design/l1_cache.sv
sim/tb_mem_model.sv
sim/tb_l1_cache.sv

//--- run.sh
#!/bin/sh
# build and run the cache testbench with Verilator, result decided from sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_l1_cache -o tb_l1_cache
./obj_dir/tb_l1_cache > sim.log 2>&1
cat sim.log

if grep -qx "Simulation PASSED" sim.log; then
    exit 0
fi
exit 1

//--- sim/tb_l1_cache.sv
// table-driven testbench for the L1 cache, default DUT parameters assumed
// 64 sets of 2-word blocks, so set index is addr[8:3] and tag starts at bit 9
`timescale 1ns/1ps

module tb_l1_cache import cache_pkg::*; ();

    localparam int    HALF_PERIOD   = 50;
    localparam int    TIMEOUT       = 200;     // cycles for one access
    localparam int    FLUSH_TIMEOUT = 3000;    // whole scan plus write-backs
    localparam word_t NONCACHE      = 32'h8000_0000;

    typedef enum logic [2:0] {OP_RD, OP_WR, OP_FLUSH, OP_MEM_OLD, OP_MEM_NEW} op_t;

    typedef struct packed {
        op_t      op;
        word_t    addr;
        word_t    wdata;
        byte_en_t be;
        logic     exp_hit;  // hit in the first cycle of the access
    } stim_t;

    logic     CLK, nRST, flush, flush_done, hit;
    bus_req_t proc_req, mem_req;
    bus_rsp_t proc_rsp, mem_rsp;
    word_t    peek_addr, peek_data;
    stim_t    stim [$];
    word_t    shadow [word_t];  // processor view of every written word
    int       errors, timeouts;

    l1_cache u_dut (
        .CLK (CLK), .nRST (nRST), .proc_req (proc_req), .proc_rsp (proc_rsp),
        .mem_req (mem_req), .mem_rsp (mem_rsp), .flush (flush),
        .flush_done (flush_done), .hit (hit)
    );

    tb_mem_model u_mem (
        .CLK (CLK), .nRST (nRST), .mem_req (mem_req), .mem_rsp (mem_rsp),
        .peek_addr (peek_addr), .peek_data (peek_data)
    );

    initial CLK = 1'b0;
    always #HALF_PERIOD CLK = ~CLK;

    function automatic word_t shadow_read(word_t a);
        word_t wa;
        wa = {a[31:2], 2'b00};
        if (shadow.exists(wa)) return shadow[wa];
        return {wa[15:0], wa[31:16]} ^ 32'h9e37_79b9;  // memory power-up content
    endfunction

    // lane rule as a mask, every set enable replaces its byte
    function automatic word_t lane_write(word_t old_w, word_t new_w, byte_en_t be);
        word_t mask;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    task automatic check(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s, got %h expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic add_row(op_t op, word_t addr, word_t wdata, byte_en_t be, logic exp_hit);
        stim.push_back('{op, addr, wdata, be, exp_hit});
    endtask

    task automatic run_access(input stim_t s);
        int   cycles;
        logic done;
        @(negedge CLK);
        proc_req.ren     = (s.op == OP_RD);
        proc_req.wen     = (s.op == OP_WR);
        proc_req.addr    = s.addr;
        proc_req.wdata   = s.wdata;
        proc_req.byte_en = s.be;
        cycles = 0;
        done   = 1'b0;
        #10;                                    // settled, well before the rising edge
        check(word_t'(hit), word_t'(s.exp_hit), $sformatf("first-cycle hit at %h", s.addr));
        while (!done && cycles < TIMEOUT) begin
            if (!proc_rsp.busy) begin
                done = 1'b1;                    // completes at the coming edge
            end else begin
                @(negedge CLK);
                #10;
                cycles++;
            end
        end
        if (!done) begin
            timeouts++;
            $display("Timeout: access to %h still busy after %0d cycles", s.addr, TIMEOUT);
        end else begin
            // a miss retries and hits, pass-through never does
            check(word_t'(hit), word_t'(s.addr < NONCACHE), $sformatf("done hit at %h", s.addr));
            if (s.op == OP_RD) begin
                check(proc_rsp.rdata, shadow_read(s.addr), $sformatf("read data at %h", s.addr));
            end else begin
                shadow[{s.addr[31:2], 2'b00}] = lane_write(shadow_read(s.addr), s.wdata, s.be);
            end
        end
        @(negedge CLK);
        proc_req.ren = 1'b0;
        proc_req.wen = 1'b0;
    endtask

    task automatic run_flush();
        int cycles;
        int pulses;
        int tail;
        @(negedge CLK);
        flush = 1'b1;
        @(negedge CLK);
        flush = 1'b0;                           // one cycle is enough in IDLE
        cycles = 0;
        pulses = 0;
        tail   = 0;
        #10;
        while (tail < 4 && cycles < FLUSH_TIMEOUT) begin
            if (flush_done) pulses++;
            if (pulses != 0) tail++;            // watch a few cycles past the pulse
            @(negedge CLK);
            #10;
            cycles++;
        end
        if (pulses == 0) begin
            timeouts++;
            $display("Timeout: flush_done never went high within %0d cycles", FLUSH_TIMEOUT);
        end else begin
            check(pulses, 1, "flush_done pulse count");
        end
    endtask

    task automatic check_memory(input stim_t s);
        word_t expected;
        @(negedge CLK);
        peek_addr = s.addr;
        #1;
        if (s.op == OP_MEM_OLD) begin
            expected = {s.addr[15:0], s.addr[31:16]} ^ 32'h9e37_79b9;    // untouched
        end else begin
            expected = shadow_read(s.addr);
        end
        check(peek_data, expected, $sformatf("memory word at %h", s.addr));
    endtask

    initial begin
        errors   = 0;
        timeouts = 0;
        nRST     = 1'b0;
        flush    = 1'b0;
        proc_req = '0;
        peek_addr = '0;

        // read miss, then rereads hit
        add_row(OP_RD, 32'h0000_0100, 32'h0, 4'hf, 1'b0);
        add_row(OP_RD, 32'h0000_0100, 32'h0, 4'hf, 1'b1);
        add_row(OP_RD, 32'h0000_0104, 32'h0, 4'hf, 1'b1);
        // byte-lane write hits stay in the cache
        add_row(OP_WR, 32'h0000_0100, 32'haaaa_aa11, 4'b0001, 1'b1);
        add_row(OP_WR, 32'h0000_0100, 32'h0000_2200, 4'b0010, 1'b1);
        add_row(OP_WR, 32'h0000_0104, 32'h1234_5678, 4'b1111, 1'b1);
        add_row(OP_WR, 32'h0000_0104, 32'habcd_0000, 4'b1100, 1'b1);
        add_row(OP_RD, 32'h0000_0100, 32'h0, 4'hf, 1'b1);
        add_row(OP_RD, 32'h0000_0104, 32'h0, 4'hf, 1'b1);
        add_row(OP_MEM_OLD, 32'h0000_0100, 32'h0, 4'h0, 1'b0);
        add_row(OP_MEM_OLD, 32'h0000_0104, 32'h0, 4'h0, 1'b0);
        // set 1: A=008, B=208, C=408, B is the LRU victim
        add_row(OP_RD, 32'h0000_0008, 32'h0, 4'hf, 1'b0);
        add_row(OP_WR, 32'h0000_0208, 32'h5555_aaaa, 4'hf, 1'b0);
        add_row(OP_RD, 32'h0000_0008, 32'h0, 4'hf, 1'b1);
        add_row(OP_RD, 32'h0000_0408, 32'h0, 4'hf, 1'b0);
        add_row(OP_MEM_NEW, 32'h0000_0208, 32'h0, 4'h0, 1'b0);
        add_row(OP_RD, 32'h0000_0008, 32'h0, 4'hf, 1'b1);
        add_row(OP_RD, 32'h0000_0408, 32'h0, 4'hf, 1'b1);
        add_row(OP_MEM_OLD, 32'h0000_0100, 32'h0, 4'h0, 1'b0);
        // pass-through region
        add_row(OP_RD, 32'h8000_0010, 32'h0, 4'hf, 1'b0);
        add_row(OP_WR, 32'h8000_0010, 32'h0000_00ef, 4'b0001, 1'b0);
        add_row(OP_MEM_NEW, 32'h8000_0010, 32'h0, 4'h0, 1'b0);
        add_row(OP_RD, 32'h8000_0010, 32'h0, 4'hf, 1'b0);
        add_row(OP_WR, 32'h8000_0010, 32'h00c0_de00, 4'b0110, 1'b0);
        add_row(OP_RD, 32'h8000_0010, 32'h0, 4'hf, 1'b0);
        add_row(OP_MEM_NEW, 32'h8000_0010, 32'h0, 4'h0, 1'b0);
        // dirty writes, flush, then memory and cache both agree
        add_row(OP_WR, 32'h0000_0300, 32'h0bad_f00d, 4'hf, 1'b0);
        add_row(OP_WR, 32'h0000_00c0, 32'h0000_7777, 4'b0011, 1'b0);
        add_row(OP_WR, 32'h0000_000c, 32'h1111_2222, 4'hf, 1'b1);
        add_row(OP_FLUSH, 32'h0, 32'h0, 4'h0, 1'b0);
        add_row(OP_MEM_NEW, 32'h0000_0100, 32'h0, 4'h0, 1'b0);
        add_row(OP_MEM_NEW, 32'h0000_0104, 32'h0, 4'h0, 1'b0);
        add_row(OP_MEM_NEW, 32'h0000_0300, 32'h0, 4'h0, 1'b0);
        add_row(OP_MEM_NEW, 32'h0000_00c0, 32'h0, 4'h0, 1'b0);
        add_row(OP_MEM_NEW, 32'h0000_000c, 32'h0, 4'h0, 1'b0);
        add_row(OP_RD, 32'h0000_0104, 32'h0, 4'hf, 1'b1);
        add_row(OP_RD, 32'h0000_0300, 32'h0, 4'hf, 1'b1);
        add_row(OP_RD, 32'h0000_00c0, 32'h0, 4'hf, 1'b1);
        add_row(OP_RD, 32'h0000_000c, 32'h0, 4'hf, 1'b1);

        repeat (8) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        #10;
        check(word_t'(proc_rsp.busy), 32'd1, "busy after reset");   // idle counts as busy
        check(word_t'(mem_req.ren | mem_req.wen), 32'd0, "memory request after reset");
        check(word_t'(flush_done), 32'd0, "flush_done after reset");

        foreach (stim[i]) begin
            case (stim[i].op)
                OP_FLUSH: run_flush();
                OP_MEM_OLD, OP_MEM_NEW: check_memory(stim[i]);
                default: run_access(stim[i]);
            endcase
        end

        repeat (2) @(negedge CLK);
        $display("errors: %0d value mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- sim/tb_mem_model.sv
// word memory behind the cache, each beat waits 0 to 2 busy cycles before completing
// unwritten words read back a pattern of their full address
`timescale 1ns/1ps

module tb_mem_model import cache_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  bus_req_t mem_req,
    output bus_rsp_t mem_rsp,
    input  word_t    peek_addr,     // side port for the testbench to inspect contents
    output word_t    peek_data
);

    word_t      mem [word_t];       // sparse, keyed by word-aligned address
    integer     seed;
    logic [1:0] wait_q;             // busy cycles left in the current beat
    logic       active;

    function automatic word_t read_word(word_t a);
        word_t wa;
        wa = {a[31:2], 2'b00};
        if (mem.exists(wa)) begin
            return mem[wa];
        end
        return {wa[15:0], wa[31:16]} ^ 32'h9e37_79b9;  // power-up pattern
    endfunction

    initial seed = 32'hffb8;

    assign active = mem_req.ren | mem_req.wen;

    always_comb begin
        mem_rsp.busy  = active && (wait_q != 2'd0);
        mem_rsp.rdata = read_word(mem_req.addr);
        peek_data     = read_word(peek_addr);
    end

    always @(posedge CLK or negedge nRST) begin
        word_t cur;
        if (!nRST) begin
            wait_q <= 2'd0;
        end else if (active) begin
            if (wait_q == 2'd0) begin   // beat completes this edge
                if (mem_req.wen) begin
                    cur = read_word(mem_req.addr);
                    for (int i = 0; i < 4; i++) begin
                        if (mem_req.byte_en[i]) cur[8*i +: 8] = mem_req.wdata[8*i +: 8];
                    end
                    mem[{mem_req.addr[31:2], 2'b00}] = cur;
                end
                wait_q <= 2'($unsigned($random(seed)) % 3);   // delay of the next beat
            end else begin
                wait_q <= wait_q - 2'd1;
            end
        end
    end

endmodule
